//--- src/mac_macros.svh
// width and size constants for the signed multiply-accumulate pipeline, included by every RTL file
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// operand and product widths
////////////////////////////////////////////////////////////////////////

// signed operand bytes
`define MAC_DATA_W 8

// full signed product of two operands
`define MAC_PROD_W 16

////////////////////////////////////////////////////////////////////////
// array shape and accumulator
////////////////////////////////////////////////////////////////////////

// one partial-product row per multiplier bit
`define MAC_ROWS 8

// running sum, wraps modulo 2^28
`define MAC_ACC_W 28

`endif

//--- src/mac_pkg.sv
// shared data types and opcode for the multiply-accumulate pipeline stages
`default_nettype none

`include "mac_macros.svh"

package mac_pkg;

  ////////////////////////////////////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////////////////////////////////////
  typedef logic signed [`MAC_DATA_W-1:0] operand_t;   // input byte
  typedef logic        [`MAC_DATA_W-1:0] magnitude_t; // |operand|, 128 fits
  typedef logic signed [`MAC_PROD_W-1:0] product_t;
  typedef logic signed [`MAC_ACC_W-1:0]  acc_t;

  // start a fresh sum or add onto the running one
  typedef enum logic {
    OP_ACCUM = 1'b0,
    OP_START = 1'b1
  } mac_op_e;

  ////////////////////////////////////////////////////////////////////////
  // stage bundles
  ////////////////////////////////////////////////////////////////////////

  // travels beside the rows through every reduction level
  typedef struct packed {
    logic    sign; // product sign
    mac_op_e op;
  } tag_t;

  typedef struct packed {
    magnitude_t [`MAC_ROWS-1:0] rows; // row i = |a| gated by bit i of |b|
    tag_t                       tag;
  } pp_bundle_t;

  typedef struct packed {
    logic [`MAC_PROD_W-1:0] mag;
    tag_t                   tag;
  } unsigned_prod_t;

  typedef struct packed {
    product_t prod;
    mac_op_e  op;
  } signed_prod_t;

endpackage

`default_nettype wire

//--- src/pp_gen_stage.sv
// first pipeline stage, forms operand magnitudes and registers the partial-product rows
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module pp_gen_stage (
  input  logic                clk,
  input  logic                rstn,
  input  logic                en,
  input  mac_pkg::operand_t   a,
  input  mac_pkg::operand_t   b,
  input  mac_pkg::mac_op_e    op,
  output mac_pkg::pp_bundle_t pp
);

  mac_pkg::magnitude_t                a_mag;
  mac_pkg::magnitude_t                b_mag;
  mac_pkg::magnitude_t [`MAC_ROWS-1:0] rows;
  logic                               sign;

  ////////////////////////////////////////////////////////////////////////
  // magnitudes
  ////////////////////////////////////////////////////////////////////////

  // -(-128) wraps to 8'h80, which reads as 128 unsigned
  assign a_mag = a[`MAC_DATA_W-1] ? mac_pkg::magnitude_t'(-a)
                                  : mac_pkg::magnitude_t'(a);
  assign b_mag = b[`MAC_DATA_W-1] ? mac_pkg::magnitude_t'(-b)
                                  : mac_pkg::magnitude_t'(b);

  assign sign = a[`MAC_DATA_W-1] ^ b[`MAC_DATA_W-1]; // restored in stage eight

  ////////////////////////////////////////////////////////////////////////
  // partial-product rows
  ////////////////////////////////////////////////////////////////////////

  // row weight 2^i is applied later by the reduction shifts
  always_comb begin
    for (int i = 0; i < `MAC_ROWS; i++) begin
      rows[i] = b_mag[i] ? a_mag : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pp.rows     <= '0;
      pp.tag.sign <= 1'b0;
      pp.tag.op   <= mac_pkg::OP_ACCUM; // bubble adds zero
    end else if (en) begin
      pp.rows     <= rows;
      pp.tag.sign <= sign;
      pp.tag.op   <= op;
    end
  end

endmodule

`default_nettype wire

//--- src/reduce_level.sv
// one reduction level of the multiplier tree, adds shifted row pairs over two register stages
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module reduce_level #(
  parameter int IN_ROWS = 8,
  parameter int IN_W    = 8,
  parameter int SHIFT   = 1
) (
  input  logic                                          clk,
  input  logic                                          rstn,
  input  logic                                          en,
  input  logic [IN_ROWS-1:0][IN_W-1:0]                  rows_in,
  input  mac_pkg::tag_t                                 tag_in,
  output logic [IN_ROWS/2-1:0][`MAC_DATA_W+2*SHIFT-1:0] rows_out,
  output mac_pkg::tag_t                                 tag_out
);

  // each output row is |a| times a 2*SHIFT bit slice of |b|
  localparam int NP    = IN_ROWS / 2;
  localparam int OUT_W = `MAC_DATA_W + 2 * SHIFT;
  localparam int LO_W  = OUT_W / 2;
  localparam int HI_W  = OUT_W - LO_W;

  logic [NP-1:0][OUT_W-1:0] even_ext;
  logic [NP-1:0][OUT_W-1:0] odd_ext;   // odd row already shifted
  logic [NP-1:0][OUT_W:0]   pair_full; // only used to check the fit
  logic [NP-1:0][LO_W:0]    lo_sum;
  logic [NP-1:0][LO_W:0]    lo_q;      // low half plus its carry
  logic [NP-1:0][HI_W-1:0]  even_hi_q;
  logic [NP-1:0][HI_W-1:0]  odd_hi_q;
  logic [NP-1:0][HI_W-1:0]  hi_sum;
  mac_pkg::tag_t            tag_q;

  ////////////////////////////////////////////////////////////////////////
  // first stage, low half add
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      even_ext[i]  = OUT_W'(rows_in[2*i]);
      odd_ext[i]   = OUT_W'(rows_in[2*i+1]) << SHIFT;
      pair_full[i] = {1'b0, even_ext[i]} + {1'b0, odd_ext[i]};
      lo_sum[i]    = {1'b0, even_ext[i][LO_W-1:0]} + {1'b0, odd_ext[i][LO_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      lo_q      <= '0;
      even_hi_q <= '0;
      odd_hi_q  <= '0;
      tag_q     <= '{sign: 1'b0, op: mac_pkg::OP_ACCUM};
    end else if (en) begin
      lo_q <= lo_sum;
      for (int i = 0; i < NP; i++) begin
        even_hi_q[i] <= even_ext[i][OUT_W-1:LO_W]; // upper bits wait a stage
        odd_hi_q[i]  <= odd_ext[i][OUT_W-1:LO_W];
      end
      tag_q <= tag_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // second stage, high half add with carry
  ////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      hi_sum[i] = even_hi_q[i] + odd_hi_q[i] + HI_W'(lo_q[i][LO_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rows_out <= '0;
      tag_out  <= '{sign: 1'b0, op: mac_pkg::OP_ACCUM};
    end else if (en) begin
      for (int i = 0; i < NP; i++) begin
        rows_out[i] <= {hi_sum[i], lo_q[i][LO_W-1:0]};
      end
      tag_out <= tag_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  // upstream rows are bounded so no pair overflows the narrower output row
  for (genvar g = 0; g < NP; g++) begin : g_fit
    a_pair_fits: assert property (@(posedge clk) disable iff (!rstn)
      pair_full[g][OUT_W] == 1'b0)
      else $error("pair %0d sum exceeds %0d bits", g, OUT_W);
  end

endmodule

`default_nettype wire

//--- src/sign_restore_stage.sv
// stage eight, turns the unsigned product magnitude back into a signed product
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module sign_restore_stage (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    en,
  input  mac_pkg::unsigned_prod_t uprod,
  output mac_pkg::signed_prod_t   sprod
);

  mac_pkg::product_t prod_pos;

  assign prod_pos = mac_pkg::product_t'(uprod.mag); // top bit always clear here

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sprod.prod <= '0;
      sprod.op   <= mac_pkg::OP_ACCUM;
    end else if (en) begin
      sprod.prod <= uprod.tag.sign ? -prod_pos : prod_pos; // two's complement when negative
      sprod.op   <= uprod.tag.op;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  // largest magnitude is 128 * 128, from the whole reduction tree
  a_mag_range: assert property (@(posedge clk) disable iff (!rstn)
    uprod.mag <= (`MAC_PROD_W'(1) << (2 * `MAC_DATA_W - 2)))
    else $error("product magnitude %0d out of range", uprod.mag);

endmodule

`default_nettype wire

//--- src/accumulate_stage.sv
// stage nine, starts or extends the running 28-bit sum from each signed product
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module accumulate_stage (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  en,
  input  mac_pkg::signed_prod_t sprod,
  output mac_pkg::acc_t         result
);

  mac_pkg::acc_t prod_ext;
  mac_pkg::acc_t acc_next;

  ////////////////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////////////////

  assign prod_ext = mac_pkg::acc_t'(sprod.prod); // sign extended

  always_comb begin
    if (sprod.op == mac_pkg::OP_START) begin
      acc_next = prod_ext; // new sum begins with this product
    end else begin
      acc_next = result + prod_ext; // wraps modulo 2^28
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else if (en) begin
      result <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  // a stalled pipeline must not move the visible sum
  a_hold_on_stall: assert property (@(posedge clk)
    (rstn && !en) |=> $stable(result))
    else $error("result changed while en was low");

  a_zero_after_reset: assert property (@(posedge clk)
    !rstn |=> (result == '0))
    else $error("result not cleared by reset");

endmodule

`default_nettype wire

//--- src/mac_top.sv
// top level of the nine-stage signed 8x8 multiply-accumulate element, plain ports only
`timescale 1ns/1ps
`default_nettype none

`include "mac_macros.svh"

module mac_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,     // stalls every stage when low
  input  mac_pkg::mac_op_e  op,
  input  mac_pkg::operand_t a,
  input  mac_pkg::operand_t b,
  output mac_pkg::acc_t     result
);

  mac_pkg::pp_bundle_t                               pp;
  logic [`MAC_ROWS/2-1:0][`MAC_DATA_W+1:0]           l1_rows; // 4 x 10
  logic [`MAC_ROWS/4-1:0][`MAC_DATA_W+3:0]           l2_rows; // 2 x 12
  logic [`MAC_ROWS/8-1:0][`MAC_PROD_W-1:0]           l3_rows; // 1 x 16
  mac_pkg::tag_t                                     l1_tag;
  mac_pkg::tag_t                                     l2_tag;
  mac_pkg::tag_t                                     l3_tag;
  mac_pkg::unsigned_prod_t                           uprod;
  mac_pkg::signed_prod_t                             sprod;

  ////////////////////////////////////////////////////////////////////////
  // stage 1 and the reduction tree, stages 2 to 7
  ////////////////////////////////////////////////////////////////////////

  pp_gen_stage pp_gen_i (
    .clk (clk), .rstn (rstn), .en (en),
    .a   (a), .b (b), .op (op),
    .pp  (pp)
  );

  reduce_level #(.IN_ROWS(`MAC_ROWS), .IN_W(`MAC_DATA_W), .SHIFT(1)) reduce_l1_i (
    .clk     (clk), .rstn (rstn), .en (en),
    .rows_in (pp.rows), .tag_in (pp.tag),
    .rows_out(l1_rows), .tag_out(l1_tag)
  );

  reduce_level #(.IN_ROWS(`MAC_ROWS/2), .IN_W(`MAC_DATA_W+2), .SHIFT(2)) reduce_l2_i (
    .clk     (clk), .rstn (rstn), .en (en),
    .rows_in (l1_rows), .tag_in (l1_tag),
    .rows_out(l2_rows), .tag_out(l2_tag)
  );

  reduce_level #(.IN_ROWS(`MAC_ROWS/4), .IN_W(`MAC_DATA_W+4), .SHIFT(4)) reduce_l3_i (
    .clk     (clk), .rstn (rstn), .en (en),
    .rows_in (l2_rows), .tag_in (l2_tag),
    .rows_out(l3_rows), .tag_out(l3_tag)
  );

  assign uprod.mag = l3_rows[0];
  assign uprod.tag = l3_tag;

  ////////////////////////////////////////////////////////////////////////
  // stages 8 and 9
  ////////////////////////////////////////////////////////////////////////

  sign_restore_stage sign_restore_i (
    .clk (clk), .rstn (rstn), .en (en),
    .uprod(uprod), .sprod(sprod)
  );

  accumulate_stage accumulate_i (
    .clk (clk), .rstn (rstn), .en (en),
    .sprod(sprod), .result(result)
  );

endmodule

`default_nettype wire

//--- sim/tb_mac_top.sv
// directed testbench for the multiply-accumulate pipeline, compiled together with flist.f
`timescale 1ns/1ps
`default_nettype none

module tb_mac_top;

  //////////////////////////////////////////////////////////////////////
  // test lengths and run limit
  //////////////////////////////////////////////////////////////////////
  localparam int PIPE_DEPTH    = 9;  // sampling edge to result update
  localparam int RESET_CYCLES  = 8;
  localparam int DOT_ITEMS     = 41;
  localparam int RESTART_ITEMS = 24;
  localparam int STALL_ITEMS   = 30;
  localparam int MAX_GAP       = 4;
  localparam int CORNER_LEN    = 5 * PIPE_DEPTH;
  localparam int DOT_LEN       = DOT_ITEMS + PIPE_DEPTH;
  localparam int RESTART_LEN   = RESTART_ITEMS + PIPE_DEPTH;
  localparam int STALL_LEN     = STALL_ITEMS * (1 + MAX_GAP) + PIPE_DEPTH;
  localparam int RESET_LEN     = 6 + 4 + 20 + PIPE_DEPTH;
  localparam int TIMEOUT_CYCLES =
    2 * (CORNER_LEN + DOT_LEN + RESTART_LEN + STALL_LEN + RESET_LEN) + RESET_CYCLES;

  logic              clk;
  logic              rstn;
  logic              en;
  mac_pkg::mac_op_e  op;
  mac_pkg::operand_t a;
  mac_pkg::operand_t b;
  mac_pkg::acc_t     result;

  mac_pkg::signed_prod_t pending[$]; // items not yet through stage nine
  mac_pkg::acc_t         exp_acc;
  logic [15:0]           lfsr_state = 16'd14;
  string                 cur_test;
  int                    cycle_count  = 0;
  int                    check_count  = 0;
  int                    err_count    = 0;
  int                    test_errs    = 0;
  int                    tests_run    = 0;
  int                    tests_failed = 0;

  mac_top mac_top_i (
    .clk    (clk),
    .rstn   (rstn),
    .en     (en),
    .op     (op),
    .a      (a),
    .b      (b),
    .result (result)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles in %s", cycle_count, cur_test);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  // galois form, taps 16,14,13,11
  function automatic logic next_lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], next_lfsr_bit()};
    end
    return v;
  endfunction

  // reset leaves eight zero bubbles ahead of the first real item
  task automatic clear_model();
    mac_pkg::signed_prod_t bubble;
    bubble.prod = '0;
    bubble.op   = mac_pkg::OP_ACCUM;
    pending.delete();
    repeat (PIPE_DEPTH - 1) pending.push_back(bubble);
    exp_acc = '0;
  endtask

  task automatic advance_model(input mac_pkg::mac_op_e op_v, input mac_pkg::operand_t a_v,
                               input mac_pkg::operand_t b_v);
    mac_pkg::signed_prod_t item;
    mac_pkg::signed_prod_t done;
    item.prod = mac_pkg::product_t'(int'(a_v) * int'(b_v));
    item.op   = op_v;
    pending.push_back(item);
    if (pending.size() >= PIPE_DEPTH) begin
      done = pending.pop_front();
      if (done.op == mac_pkg::OP_START) begin
        exp_acc = mac_pkg::acc_t'(int'(done.prod));
      end else begin
        exp_acc = exp_acc + mac_pkg::acc_t'(int'(done.prod)); // wraps at 28 bits
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking, driving and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic compare_acc(input string name, input mac_pkg::acc_t expected,
                             input mac_pkg::acc_t actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      err_count = err_count + 1;
      test_errs = test_errs + 1;
      $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // starts and ends at a falling edge, one clock per call
  task automatic drive_cycle(input logic en_v, input mac_pkg::mac_op_e op_v,
                             input mac_pkg::operand_t a_v, input mac_pkg::operand_t b_v);
    en = en_v;
    op = op_v;
    a  = a_v;
    b  = b_v;
    @(posedge clk);
    if (en_v) begin
      advance_model(op_v, a_v, b_v);
    end
    @(negedge clk);
    compare_acc(cur_test, exp_acc, result);
  endtask

  task automatic drain_pipe();
    repeat (PIPE_DEPTH - 1) drive_cycle(1'b1, mac_pkg::OP_ACCUM, 8'sd0, 8'sd0);
  endtask

  task automatic apply_reset(input int n);
    rstn = 1'b0;
    en   = 1'b1;              // reset must win over a live input
    op   = mac_pkg::OP_START;
    a    = 8'sd5;
    b    = 8'sd7;
    repeat (n) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    clear_model();
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic report_test();
    tests_run = tests_run + 1;
    if (test_errs != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("%s finished, %0d errors", cur_test, test_errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic corner_products();
    mac_pkg::operand_t xs[5] = '{-8'sd128, -8'sd128, 8'sd127, 8'sd0, -8'sd1};
    mac_pkg::operand_t ys[5] = '{-8'sd128, 8'sd127, 8'sd127, -8'sd77, 8'sd1};
    start_test("corner_products");
    for (int i = 0; i < 5; i++) begin
      drive_cycle(1'b1, mac_pkg::OP_START, xs[i], ys[i]);
      drain_pipe();
      compare_acc(cur_test, mac_pkg::acc_t'(int'(xs[i]) * int'(ys[i])), result);
    end
    report_test();
  endtask

  task automatic random_dot_product();
    mac_pkg::operand_t x;
    mac_pkg::operand_t y;
    start_test("random_dot_product");
    for (int i = 0; i < DOT_ITEMS; i++) begin
      x = mac_pkg::operand_t'(random_bits(8));
      y = mac_pkg::operand_t'(random_bits(8));
      drive_cycle(1'b1, (i == 0) ? mac_pkg::OP_START : mac_pkg::OP_ACCUM, x, y);
    end
    drain_pipe();
    report_test();
  endtask

  // starts at 7 and 10 are in flight together
  task automatic restart_mid_stream();
    mac_pkg::operand_t x;
    mac_pkg::operand_t y;
    mac_pkg::mac_op_e  op_v;
    start_test("restart_mid_stream");
    for (int i = 0; i < RESTART_ITEMS; i++) begin
      x    = mac_pkg::operand_t'(random_bits(8));
      y    = mac_pkg::operand_t'(random_bits(8));
      op_v = (i == 0 || i == 7 || i == 10 || i == 17) ? mac_pkg::OP_START
                                                       : mac_pkg::OP_ACCUM;
      drive_cycle(1'b1, op_v, x, y);
    end
    drain_pipe();
    report_test();
  endtask

  task automatic stall_stream();
    int                gap;
    mac_pkg::operand_t x;
    mac_pkg::operand_t y;
    start_test("stall_stream");
    for (int i = 0; i < STALL_ITEMS; i++) begin
      if (i > 0 && next_lfsr_bit()) begin
        gap = 1 + int'(random_bits(2));
        // junk on the inputs, ignored while en is low
        repeat (gap) drive_cycle(1'b0, mac_pkg::OP_START, 8'sd99, -8'sd99);
      end
      x = mac_pkg::operand_t'(random_bits(8));
      y = mac_pkg::operand_t'(random_bits(8));
      drive_cycle(1'b1, (i == 0) ? mac_pkg::OP_START : mac_pkg::OP_ACCUM, x, y);
    end
    drain_pipe();
    report_test();
  endtask

  task automatic reset_in_flight();
    mac_pkg::operand_t x;
    mac_pkg::operand_t y;
    start_test("reset_in_flight");
    drive_cycle(1'b1, mac_pkg::OP_START, 8'sd100, 8'sd90);
    for (int i = 0; i < 5; i++) begin
      drive_cycle(1'b1, mac_pkg::OP_ACCUM, -8'sd120, 8'sd111);
    end
    apply_reset(3);
    compare_acc(cur_test, '0, result);
    for (int i = 0; i < 20; i++) begin
      x = mac_pkg::operand_t'(random_bits(8));
      y = mac_pkg::operand_t'(random_bits(8));
      drive_cycle(1'b1, mac_pkg::OP_ACCUM, x, y); // no start, sums from zero
    end
    drain_pipe();
    report_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstn     = 1'b0;
    en       = 1'b0;
    op       = mac_pkg::OP_ACCUM;
    a        = '0;
    b        = '0;
    cur_test = "power_on_reset";
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    corner_products();
    random_dot_product();
    restart_mid_stream();
    stall_stream();
    reset_in_flight();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/mac_pkg.sv
src/pp_gen_stage.sv
src/reduce_level.sv
src/sign_restore_stage.sv
src/accumulate_stage.sv
src/mac_top.sv
sim/tb_mac_top.sv
